// ==== design/turf_pkg.sv ====
package turf_pkg;

    //////////////////////////////////////////////////
    // Widths that carry a meaning
    //////////////////////////////////////////////////

    // APB byte address
    typedef logic [7:0] apb_addr_t;

    // Register data word
    typedef logic [31:0] reg_word_t;

    // EMIO general-purpose bank
    typedef logic [15:0] emio_word_t;

    // Two bits of bridge type per TURFIO
    typedef logic [7:0] bridge_type_t;

    // One bit per TURFIO
    typedef logic [3:0] tio_vec_t;

    // Slave sequencing for the inserted wait state
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } apb_state_t;

    //////////////////////////////////////////////////
    // Bridge type codes
    //////////////////////////////////////////////////

    // Codes 2 and 3 are reserved and never valid
    localparam logic [1:0] BRIDGE_NONE   = 2'd0;
    localparam logic [1:0] BRIDGE_AURORA = 2'd1;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    localparam apb_addr_t ADDR_IDENT       = 8'h00;
    localparam apb_addr_t ADDR_DATEVERSION = 8'h04;
    localparam apb_addr_t ADDR_GPIO_OUT    = 8'h08;
    localparam apb_addr_t ADDR_GPIO_TRI    = 8'h0C;
    localparam apb_addr_t ADDR_GPIO_IN     = 8'h10;
    localparam apb_addr_t ADDR_BRIDGE_TYPE = 8'h14;
    localparam apb_addr_t ADDR_BRIDGE_STAT = 8'h18;

    //////////////////////////////////////////////////
    // Identification
    //////////////////////////////////////////////////

    // ASCII "TURF"
    localparam reg_word_t IDENT_WORD = 32'h5455_5246;

    localparam logic        REVISION_B    = 1'b0;
    localparam logic [15:0] FIRMWARE_DATE = 16'h0000;
    localparam logic [3:0]  VER_MAJOR     = 4'd0;
    localparam logic [3:0]  VER_MINOR     = 4'd7;
    localparam logic [7:0]  VER_REV       = 8'd19;

    // Revision bit, 15 bits of date, then major/minor/rev
    localparam reg_word_t DATEVERSION_WORD = {REVISION_B, FIRMWARE_DATE[14:0],
                                              VER_MAJOR, VER_MINOR, VER_REV};

    //////////////////////////////////////////////////
    // EMIO bit positions
    //////////////////////////////////////////////////

    localparam int EMIO_TRESET_LSB = 12;
    localparam int EMIO_EXTINT_LSB = 8;
    localparam int EMIO_PPS_BIT    = 10;
    localparam int EMIO_TP1_BIT    = 11;

    //////////////////////////////////////////////////
    // 16x baud tick increments
    //////////////////////////////////////////////////

    // 82/1024 of ps_clk is within 0.1% of the housekeeping 16x rate
    localparam int                    HSK_FRAC_W = 10;
    localparam logic [HSK_FRAC_W-1:0] HSK_ADD    = 10'd82;

    // GPS at 38400 baud, 25/4096
    localparam int                    GPS_FRAC_W = 12;
    localparam logic [GPS_FRAC_W-1:0] GPS_ADD    = 12'd25;

endpackage

// ==== design/turf_apb_regs.sv ====
module turf_apb_regs (
    input  logic                    ps_clk,
    input  logic                    reset_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  turf_pkg::apb_addr_t     paddr_i,
    input  turf_pkg::reg_word_t     pwdata_i,
    output turf_pkg::reg_word_t     prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    output turf_pkg::emio_word_t    gpio_out_o,
    output turf_pkg::emio_word_t    gpio_tri_o,
    input  turf_pkg::emio_word_t    gpio_in_i,
    output logic                    pps_clear_o,
    output turf_pkg::bridge_type_t  bridge_type_o,
    output turf_pkg::tio_vec_t      bridge_clear_o,
    input  turf_pkg::tio_vec_t      bridge_valid_i,
    input  turf_pkg::tio_vec_t      bridge_invalid_i
);

    // All pads start tristated
    localparam turf_pkg::emio_word_t GPIO_TRI_RESET = '1;

    turf_pkg::apb_state_t   state_q;
    turf_pkg::apb_state_t   state_d;
    turf_pkg::emio_word_t   gpio_out_q;
    turf_pkg::emio_word_t   gpio_tri_q;
    turf_pkg::bridge_type_t bridge_type_q;
    turf_pkg::reg_word_t    rd_data;
    logic                   addr_hit;
    logic                   read_only;
    logic                   access_err;
    logic                   wr_en;

    //////////////////////////////////////////////////
    // Transfer sequencing
    //////////////////////////////////////////////////

    // Setup, one wait cycle, then completion
    always_comb begin
        state_d = state_q;
        case (state_q)
            turf_pkg::IDLE: begin
                if (psel_i) begin
                    state_d = turf_pkg::ACCESS;
                end
            end
            turf_pkg::ACCESS: begin
                if (!psel_i) begin
                    state_d = turf_pkg::IDLE;
                end else if (penable_i) begin
                    state_d = turf_pkg::DONE;
                end
            end
            default: begin
                state_d = turf_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            state_q <= turf_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign pready_o = (state_q == turf_pkg::DONE) && psel_i && penable_i;
    assign wr_en    = pready_o && pwrite_i;

    //////////////////////////////////////////////////
    // Address decode and read mux
    //////////////////////////////////////////////////

    always_comb begin
        rd_data   = '0;
        addr_hit  = 1'b1;
        read_only = 1'b0;
        case (paddr_i)
            turf_pkg::ADDR_IDENT: begin
                rd_data   = turf_pkg::IDENT_WORD;
                read_only = 1'b1;
            end
            turf_pkg::ADDR_DATEVERSION: begin
                rd_data   = turf_pkg::DATEVERSION_WORD;
                read_only = 1'b1;
            end
            turf_pkg::ADDR_GPIO_OUT:    rd_data = {16'h0000, gpio_out_q};
            turf_pkg::ADDR_GPIO_TRI:    rd_data = {16'h0000, gpio_tri_q};
            turf_pkg::ADDR_GPIO_IN: begin
                rd_data   = {16'h0000, gpio_in_i};
                read_only = 1'b1;
            end
            turf_pkg::ADDR_BRIDGE_TYPE: rd_data = {24'h000000, bridge_type_q};
            turf_pkg::ADDR_BRIDGE_STAT: begin
                rd_data = {24'h000000, bridge_invalid_i, bridge_valid_i};
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    assign access_err = !addr_hit || (pwrite_i && read_only);
    assign pslverr_o  = pready_o && access_err;
    assign prdata_o   = pready_o ? rd_data : '0;

    //////////////////////////////////////////////////
    // Register storage
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            gpio_out_q    <= '0;
            gpio_tri_q    <= GPIO_TRI_RESET;
            bridge_type_q <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                turf_pkg::ADDR_GPIO_OUT:    gpio_out_q    <= pwdata_i[15:0];
                turf_pkg::ADDR_GPIO_TRI:    gpio_tri_q    <= pwdata_i[15:0];
                turf_pkg::ADDR_BRIDGE_TYPE: bridge_type_q <= pwdata_i[7:0];
                default: ;
            endcase
        end
    end

    // Write-1 clears, still honoured on the erroring GPIO_IN write
    assign pps_clear_o = wr_en && (paddr_i == turf_pkg::ADDR_GPIO_IN)
                         && pwdata_i[turf_pkg::EMIO_PPS_BIT];

    assign bridge_clear_o = (wr_en && (paddr_i == turf_pkg::ADDR_BRIDGE_STAT)) ?
                            pwdata_i[3:0] : '0;

    assign gpio_out_o    = gpio_out_q;
    assign gpio_tri_o    = gpio_tri_q;
    assign bridge_type_o = bridge_type_q;

endmodule

// ==== design/turf_emio_gpio.sv ====
module turf_emio_gpio (
    input  logic                 ps_clk,
    input  logic                 reset_i,
    input  turf_pkg::emio_word_t gpio_out_i,
    input  turf_pkg::emio_word_t gpio_tri_i,
    input  logic                 pps_clear_i,
    output turf_pkg::tio_vec_t   tresetb_o,
    output turf_pkg::tio_vec_t   tresetb_oe_o,
    input  turf_pkg::tio_vec_t   tresetb_i,
    output logic [1:0]           gps_extint_o,
    input  logic [1:0]           gps_timepulse_i,
    input  logic                 hsk_irq_i,
    input  logic                 hsk_complete_i,
    input  logic                 uart_irq_b_i,
    output turf_pkg::emio_word_t gpio_in_o
);

    turf_pkg::tio_vec_t tresetb_s1_q;
    turf_pkg::tio_vec_t tresetb_s2_q;
    logic [1:0]         tp_s1_q;
    logic [1:0]         tp_s2_q;
    logic               tp0_s3_q;
    logic [2:0]         hsk_s1_q;
    logic [2:0]         hsk_s2_q;
    logic               pps_flag_q;
    logic               pps_rise;

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    // TURFIO resets are active low, pad enabled when not tristated
    assign tresetb_o    = gpio_out_i[turf_pkg::EMIO_TRESET_LSB +: 4];
    assign tresetb_oe_o = ~gpio_tri_i[turf_pkg::EMIO_TRESET_LSB +: 4];

    assign gps_extint_o = gpio_out_i[turf_pkg::EMIO_EXTINT_LSB +: 2]
                          & ~gpio_tri_i[turf_pkg::EMIO_EXTINT_LSB +: 2];

    //////////////////////////////////////////////////
    // Input synchronizers
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            tresetb_s1_q <= '0;
            tresetb_s2_q <= '0;
            tp_s1_q      <= '0;
            tp_s2_q      <= '0;
            tp0_s3_q     <= 1'b0;
            hsk_s1_q     <= '0;
            hsk_s2_q     <= '0;
        end else begin
            tresetb_s1_q <= tresetb_i;
            tresetb_s2_q <= tresetb_s1_q;
            tp_s1_q      <= gps_timepulse_i;
            tp_s2_q      <= tp_s1_q;
            // Extra stage only for the PPS edge detect
            tp0_s3_q     <= tp_s2_q[0];
            hsk_s1_q     <= {hsk_complete_i, hsk_irq_i, uart_irq_b_i};
            hsk_s2_q     <= hsk_s1_q;
        end
    end

    // Sticky PPS flag, clear takes priority
    assign pps_rise = tp_s2_q[0] && !tp0_s3_q;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            pps_flag_q <= 1'b0;
        end else if (pps_clear_i) begin
            pps_flag_q <= 1'b0;
        end else if (pps_rise) begin
            pps_flag_q <= 1'b1;
        end
    end

    always_comb begin
        gpio_in_o = '0;
        gpio_in_o[turf_pkg::EMIO_TRESET_LSB +: 4] = tresetb_s2_q;
        gpio_in_o[turf_pkg::EMIO_TP1_BIT]         = tp_s2_q[1];
        gpio_in_o[turf_pkg::EMIO_PPS_BIT]         = pps_flag_q;
        gpio_in_o[2:0]                            = hsk_s2_q;
    end

endmodule

// ==== design/turf_bridge_select.sv ====
module turf_bridge_select (
    input  logic                   ps_clk,
    input  logic                   reset_i,
    input  turf_pkg::bridge_type_t bridge_type_i,
    input  turf_pkg::tio_vec_t     bridge_clear_i,
    input  turf_pkg::tio_vec_t     aurora_up_i,
    output turf_pkg::tio_vec_t     bridge_valid_o,
    output turf_pkg::tio_vec_t     bridge_invalid_o
);

    turf_pkg::tio_vec_t valid;
    turf_pkg::tio_vec_t invalid_q;

    // NONE is always usable, AURORA only with its link up
    always_comb begin
        for (int i = 0; i < $bits(turf_pkg::tio_vec_t); i++) begin
            valid[i] = (bridge_type_i[2*i +: 2] == turf_pkg::BRIDGE_NONE)
                       || ((bridge_type_i[2*i +: 2] == turf_pkg::BRIDGE_AURORA)
                           && aurora_up_i[i]);
        end
    end

    //////////////////////////////////////////////////
    // Sticky invalid flags
    //////////////////////////////////////////////////

    // Clear wins, so a persistent fault sets again next cycle
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            invalid_q <= '0;
        end else begin
            invalid_q <= (invalid_q | ~valid) & ~bridge_clear_i;
        end
    end

    assign bridge_valid_o   = valid;
    assign bridge_invalid_o = invalid_q;

endmodule

// ==== design/turf_baud_ticks.sv ====
module turf_baud_ticks (
    input  logic ps_clk,
    input  logic reset_i,
    output logic hsk_tick_o,
    output logic gps_tick_o
);

    // Top bit of each accumulator holds the last carry
    logic [turf_pkg::HSK_FRAC_W:0] hsk_acc_q;
    logic [turf_pkg::GPS_FRAC_W:0] gps_acc_q;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            hsk_acc_q <= '0;
            gps_acc_q <= '0;
        end else begin
            hsk_acc_q <= {1'b0, hsk_acc_q[turf_pkg::HSK_FRAC_W-1:0]} + turf_pkg::HSK_ADD;
            gps_acc_q <= {1'b0, gps_acc_q[turf_pkg::GPS_FRAC_W-1:0]} + turf_pkg::GPS_ADD;
        end
    end

    assign hsk_tick_o = hsk_acc_q[turf_pkg::HSK_FRAC_W];
    assign gps_tick_o = gps_acc_q[turf_pkg::GPS_FRAC_W];

endmodule

// ==== design/turf_ctrl_top.sv ====
module turf_ctrl_top (
    input  logic                ps_clk,
    input  logic                reset_i,
    // APB slave
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  turf_pkg::apb_addr_t paddr_i,
    input  turf_pkg::reg_word_t pwdata_i,
    output turf_pkg::reg_word_t prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    // Pads
    output turf_pkg::tio_vec_t  tresetb_o,
    output turf_pkg::tio_vec_t  tresetb_oe_o,
    input  turf_pkg::tio_vec_t  tresetb_i,
    output logic [1:0]          gps_extint_o,
    input  logic [1:0]          gps_timepulse_i,
    // Housekeeping
    input  logic                hsk_irq_i,
    input  logic                hsk_complete_i,
    input  logic                uart_irq_b_i,
    input  turf_pkg::tio_vec_t  aurora_up_i,
    // Serial debug ticks
    output logic                hsk_tick_o,
    output logic                gps_tick_o
);

    turf_pkg::emio_word_t   gpio_out;
    turf_pkg::emio_word_t   gpio_tri;
    turf_pkg::emio_word_t   gpio_in;
    logic                   pps_clear;
    turf_pkg::bridge_type_t bridge_type;
    turf_pkg::tio_vec_t     bridge_clear;
    turf_pkg::tio_vec_t     bridge_valid;
    turf_pkg::tio_vec_t     bridge_invalid;

    //////////////////////////////////////////////////
    // Register block
    //////////////////////////////////////////////////

    turf_apb_regs u_regs (
        .ps_clk           (ps_clk),
        .reset_i          (reset_i),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .paddr_i          (paddr_i),
        .pwdata_i         (pwdata_i),
        .prdata_o         (prdata_o),
        .pready_o         (pready_o),
        .pslverr_o        (pslverr_o),
        .gpio_out_o       (gpio_out),
        .gpio_tri_o       (gpio_tri),
        .gpio_in_i        (gpio_in),
        .pps_clear_o      (pps_clear),
        .bridge_type_o    (bridge_type),
        .bridge_clear_o   (bridge_clear),
        .bridge_valid_i   (bridge_valid),
        .bridge_invalid_i (bridge_invalid)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    turf_emio_gpio u_emio (
        .ps_clk          (ps_clk),
        .reset_i         (reset_i),
        .gpio_out_i      (gpio_out),
        .gpio_tri_i      (gpio_tri),
        .pps_clear_i     (pps_clear),
        .tresetb_o       (tresetb_o),
        .tresetb_oe_o    (tresetb_oe_o),
        .tresetb_i       (tresetb_i),
        .gps_extint_o    (gps_extint_o),
        .gps_timepulse_i (gps_timepulse_i),
        .hsk_irq_i       (hsk_irq_i),
        .hsk_complete_i  (hsk_complete_i),
        .uart_irq_b_i    (uart_irq_b_i),
        .gpio_in_o       (gpio_in)
    );

    turf_bridge_select u_bridge (
        .ps_clk           (ps_clk),
        .reset_i          (reset_i),
        .bridge_type_i    (bridge_type),
        .bridge_clear_i   (bridge_clear),
        .aurora_up_i      (aurora_up_i),
        .bridge_valid_o   (bridge_valid),
        .bridge_invalid_o (bridge_invalid)
    );

    // Free running, no register access
    turf_baud_ticks u_ticks (
        .ps_clk     (ps_clk),
        .reset_i    (reset_i),
        .hsk_tick_o (hsk_tick_o),
        .gps_tick_o (gps_tick_o)
    );

endmodule

// ==== dv/turf_ctrl_properties.sv ====
module turf_ctrl_properties (
    input logic ps_clk,
    input logic reset_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_o,
    input logic pslverr_o,
    input logic hsk_tick_o,
    input logic gps_tick_o
);

    // Number of failed assertions
    int failures = 0;

    // Ready only inside an access phase
    ready_in_access: assert property (@(posedge ps_clk) disable iff (reset_i)
        pready_o |-> (psel_i && penable_i))
        else begin
            $error("pready_o high without psel_i and penable_i");
            failures++;
        end

    slverr_with_ready: assert property (@(posedge ps_clk) disable iff (reset_i)
        pslverr_o |-> pready_o)
        else begin
            $error("pslverr_o high without pready_o");
            failures++;
        end

    // Both tick rates are far below half the clock
    hsk_tick_single: assert property (@(posedge ps_clk) disable iff (reset_i)
        hsk_tick_o |=> !hsk_tick_o)
        else begin
            $error("hsk_tick_o high on two cycles in a row");
            failures++;
        end

    gps_tick_single: assert property (@(posedge ps_clk) disable iff (reset_i)
        gps_tick_o |=> !gps_tick_o)
        else begin
            $error("gps_tick_o high on two cycles in a row");
            failures++;
        end

endmodule

bind turf_ctrl_top turf_ctrl_properties i_turf_ctrl_properties (
    .ps_clk     (ps_clk),
    .reset_i    (reset_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .hsk_tick_o (hsk_tick_o),
    .gps_tick_o (gps_tick_o)
);

// ==== dv/turf_ctrl_tb.sv ====
module turf_ctrl_tb;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 16;
    localparam int TICK_WINDOW  = 4096;
    localparam int APB_TIMEOUT  = 8;
    // Cycle budget per test in run order
    localparam int RUN_CYCLES   = RESET_CYCLES + (TICK_WINDOW + 8) + 40 + 120 + 80 + 80 + 20;

    logic                   ps_clk;
    logic                   reset_i;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    turf_pkg::apb_addr_t    paddr_i;
    turf_pkg::reg_word_t    pwdata_i;
    turf_pkg::reg_word_t    prdata_o;
    logic                   pready_o;
    logic                   pslverr_o;
    turf_pkg::tio_vec_t     tresetb_o;
    turf_pkg::tio_vec_t     tresetb_oe_o;
    turf_pkg::tio_vec_t     tresetb_i;
    logic [1:0]             gps_extint_o;
    logic [1:0]             gps_timepulse_i;
    logic                   hsk_irq_i;
    logic                   hsk_complete_i;
    logic                   uart_irq_b_i;
    turf_pkg::tio_vec_t     aurora_up_i;
    logic                   hsk_tick_o;
    logic                   gps_tick_o;

    integer seed;
    int     errors;
    int     tests_passed;
    int     tests_failed;

    turf_ctrl_top i_turf_ctrl_top (
        .ps_clk          (ps_clk),
        .reset_i         (reset_i),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .prdata_o        (prdata_o),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o),
        .tresetb_o       (tresetb_o),
        .tresetb_oe_o    (tresetb_oe_o),
        .tresetb_i       (tresetb_i),
        .gps_extint_o    (gps_extint_o),
        .gps_timepulse_i (gps_timepulse_i),
        .hsk_irq_i       (hsk_irq_i),
        .hsk_complete_i  (hsk_complete_i),
        .uart_irq_b_i    (uart_irq_b_i),
        .aurora_up_i     (aurora_up_i),
        .hsk_tick_o      (hsk_tick_o),
        .gps_tick_o      (gps_tick_o)
    );

    always #(CLK_HALF) ps_clk = ~ps_clk;

    //////////////////////////////////////////////////
    // Checking and APB access
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input turf_pkg::reg_word_t expected,
                               input turf_pkg::reg_word_t actual);
        assert (actual === expected) else begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Setup phase, access phase, then hold until pready_o
    task automatic apb_transfer(input logic write, input turf_pkg::apb_addr_t addr,
                                input turf_pkg::reg_word_t wdata,
                                output turf_pkg::reg_word_t rdata, output logic err);
        int waited;
        waited = 0;
        @(negedge ps_clk);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge ps_clk);
        penable_i = 1'b1;
        @(negedge ps_clk);
        while (!pready_o && waited < APB_TIMEOUT) begin
            @(negedge ps_clk);
            waited++;
        end
        assert (pready_o) else begin
            $display("APB transfer to address %h never completed", addr);
            errors++;
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge ps_clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input turf_pkg::apb_addr_t addr, input turf_pkg::reg_word_t data,
                             output logic err);
        turf_pkg::reg_word_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input turf_pkg::apb_addr_t addr, output turf_pkg::reg_word_t data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    // Starts on the negedge that releases reset
    task automatic baud_tick_counts();
        int start;
        int hsk_count;
        int gps_count;
        int hsk_exp;
        int gps_exp;
        start     = errors;
        hsk_count = 0;
        gps_count = 0;
        hsk_exp   = (TICK_WINDOW * 82) / 1024;
        gps_exp   = (TICK_WINDOW * 25) / 4096;
        repeat (TICK_WINDOW) begin
            @(negedge ps_clk);
            hsk_count += int'(hsk_tick_o);
            gps_count += int'(gps_tick_o);
        end
        assert (hsk_count >= hsk_exp - 1 && hsk_count <= hsk_exp + 1) else begin
            $display("ERROR hsk_tick_o count expected %h actual %h", hsk_exp, hsk_count);
            errors++;
        end
        assert (gps_count >= gps_exp - 1 && gps_count <= gps_exp + 1) else begin
            $display("ERROR gps_tick_o count expected %h actual %h", gps_exp, gps_count);
            errors++;
        end
        report_test("baud tick counts", start);
    endtask

    task automatic ident_regs();
        int                  start;
        turf_pkg::reg_word_t rdata;
        logic                err;
        start = errors;
        apb_read(turf_pkg::ADDR_IDENT, rdata, err);
        check_value("prdata_o (IDENT)", 32'h5455_5246, rdata);
        check_value("pslverr_o (IDENT read)", 32'h0, 32'(err));
        apb_read(turf_pkg::ADDR_DATEVERSION, rdata, err);
        check_value("prdata_o (DATEVERSION)", 32'h0000_0713, rdata);
        check_value("pslverr_o (DATEVERSION read)", 32'h0, 32'(err));
        apb_write(turf_pkg::ADDR_IDENT, 32'h1234_5678, err);
        check_value("pslverr_o (IDENT write)", 32'h1, 32'(err));
        apb_write(turf_pkg::ADDR_DATEVERSION, 32'hffff_ffff, err);
        check_value("pslverr_o (DATEVERSION write)", 32'h1, 32'(err));
        apb_read(turf_pkg::ADDR_IDENT, rdata, err);
        check_value("prdata_o (IDENT after write)", 32'h5455_5246, rdata);
        report_test("ident registers", start);
    endtask

    task automatic gpio_output_gating();
        int                   start;
        int                   i;
        logic [15:0]          out_pat;
        logic [15:0]          tri_pat;
        turf_pkg::reg_word_t  rdata;
        logic                 err;
        start = errors;
        for (i = 0; i < 4; i++) begin
            out_pat = 16'($random(seed));
            tri_pat = 16'($random(seed));
            apb_write(turf_pkg::ADDR_GPIO_OUT, {16'h0, out_pat}, err);
            apb_write(turf_pkg::ADDR_GPIO_TRI, {16'h0, tri_pat}, err);
            check_value("tresetb_o", 32'(out_pat[15:12]), 32'(tresetb_o));
            check_value("tresetb_oe_o", {28'h0, ~tri_pat[15:12]}, 32'(tresetb_oe_o));
            check_value("gps_extint_o", {30'h0, out_pat[9:8] & ~tri_pat[9:8]},
                        32'(gps_extint_o));
            apb_read(turf_pkg::ADDR_GPIO_OUT, rdata, err);
            check_value("prdata_o (GPIO_OUT)", {16'h0, out_pat}, rdata);
            apb_read(turf_pkg::ADDR_GPIO_TRI, rdata, err);
            check_value("prdata_o (GPIO_TRI)", {16'h0, tri_pat}, rdata);
        end
        report_test("gpio output gating", start);
    endtask

    task automatic gpio_input_sampling();
        int                  start;
        turf_pkg::reg_word_t rdata;
        turf_pkg::reg_word_t expected;
        logic                err;
        start = errors;
        @(negedge ps_clk);
        tresetb_i       = 4'b1010;
        hsk_complete_i  = 1'b1;
        hsk_irq_i       = 1'b0;
        uart_irq_b_i    = 1'b1;
        gps_timepulse_i = 2'b10;
        repeat (3) @(negedge ps_clk);
        // Resets, timepulse 1, PPS flag, seven zeros, then the three housekeeping lines
        expected = {16'h0, 4'b1010, 1'b1, 1'b0, 7'b0, 1'b1, 1'b0, 1'b1};
        apb_read(turf_pkg::ADDR_GPIO_IN, rdata, err);
        check_value("prdata_o (GPIO_IN)", expected, rdata);
        gps_timepulse_i[0] = 1'b1;
        hsk_complete_i     = 1'b0;
        hsk_irq_i          = 1'b1;
        expected = {16'h0, 4'b1010, 1'b1, 1'b0, 7'b0, 1'b0, 1'b1, 1'b1};
        repeat (2) @(negedge ps_clk);
        gps_timepulse_i[0] = 1'b0;
        repeat (4) @(negedge ps_clk);
        apb_read(turf_pkg::ADDR_GPIO_IN, rdata, err);
        check_value("prdata_o (GPIO_IN with PPS)", expected | 32'h0000_0400, rdata);
        apb_write(turf_pkg::ADDR_GPIO_IN, 32'h0000_0400, err);
        check_value("pslverr_o (GPIO_IN write)", 32'h1, 32'(err));
        apb_read(turf_pkg::ADDR_GPIO_IN, rdata, err);
        check_value("prdata_o (GPIO_IN after clear)", expected, rdata);
        report_test("gpio input sampling", start);
    endtask

    task automatic bridge_validity();
        int                  start;
        turf_pkg::reg_word_t rdata;
        logic                err;
        start = errors;
        @(negedge ps_clk);
        aurora_up_i = 4'b0101;
        // TURFIO 3..0 select code 2, AURORA, AURORA, NONE
        apb_write(turf_pkg::ADDR_BRIDGE_TYPE, 32'h0000_0094, err);
        apb_write(turf_pkg::ADDR_BRIDGE_STAT, 32'h0000_000f, err);
        apb_read(turf_pkg::ADDR_BRIDGE_STAT, rdata, err);
        check_value("prdata_o (BRIDGE_STAT)", 32'h0000_00a5, rdata);
        // Link 1 comes up but its flag stays set
        aurora_up_i = 4'b1111;
        apb_read(turf_pkg::ADDR_BRIDGE_STAT, rdata, err);
        check_value("prdata_o (BRIDGE_STAT sticky)", 32'h0000_00a7, rdata);
        apb_write(turf_pkg::ADDR_BRIDGE_STAT, 32'h0000_000f, err);
        apb_read(turf_pkg::ADDR_BRIDGE_STAT, rdata, err);
        check_value("prdata_o (BRIDGE_STAT cleared)", 32'h0000_0087, rdata);
        apb_write(turf_pkg::ADDR_BRIDGE_TYPE, 32'h0000_0000, err);
        apb_write(turf_pkg::ADDR_BRIDGE_STAT, 32'h0000_000f, err);
        apb_read(turf_pkg::ADDR_BRIDGE_STAT, rdata, err);
        check_value("prdata_o (BRIDGE_STAT all NONE)", 32'h0000_000f, rdata);
        report_test("bridge validity", start);
    endtask

    task automatic unmapped_access();
        int                  start;
        turf_pkg::reg_word_t rdata;
        logic                err;
        start = errors;
        apb_read(8'h40, rdata, err);
        check_value("pslverr_o (address 0x40)", 32'h1, 32'(err));
        apb_read(turf_pkg::ADDR_IDENT, rdata, err);
        check_value("pslverr_o (IDENT after error)", 32'h0, 32'(err));
        check_value("prdata_o (IDENT after error)", 32'h5455_5246, rdata);
        report_test("unmapped access", start);
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        ps_clk          = 1'b0;
        reset_i         = 1'b1;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        pwrite_i        = 1'b0;
        paddr_i         = '0;
        pwdata_i        = '0;
        tresetb_i       = '0;
        gps_timepulse_i = '0;
        hsk_irq_i       = 1'b0;
        hsk_complete_i  = 1'b0;
        uart_irq_b_i    = 1'b0;
        aurora_up_i     = '0;
        seed            = 32'hb869_7642;
        errors          = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (RESET_CYCLES) @(negedge ps_clk);
        reset_i = 1'b0;
        baud_tick_counts();
        ident_regs();
        gpio_output_gating();
        gpio_input_sampling();
        bridge_validity();
        unmapped_access();
        $display("Tests passed: %0d, failed: %0d, property failures: %0d",
                 tests_passed, tests_failed,
                 i_turf_ctrl_top.i_turf_ctrl_properties.failures);
        if (errors == 0 && i_turf_ctrl_top.i_turf_ctrl_properties.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(2 * RUN_CYCLES * 2 * CLK_HALF);
        $display("Watchdog expired before all tests completed");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
design/turf_pkg.sv
design/turf_apb_regs.sv
design/turf_emio_gpio.sv
design/turf_bridge_select.sv
design/turf_baud_ticks.sv
design/turf_ctrl_top.sv
dv/turf_ctrl_properties.sv
dv/turf_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module turf_ctrl_tb -Mdir obj_dir -f all.f

out=$(./obj_dir/Vturf_ctrl_tb)
echo "$out"
echo "$out" | grep -qx "TB PASSED"
